//--- all.f
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob_entry_array.sv
rtl/rob_flush_ctrl.sv
rtl/rob_retire_select.sv
rtl/rob_top.sv
verif/tb_clock_gen.sv
verif/rob_tb.sv

//--- rtl/rob_config.svh
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// depth is 2**ROB_SIZE_LOG, ids carry one extra wrap bit
`define ROB_SIZE_LOG 4
`define ROB_SIZE     (1 << `ROB_SIZE_LOG)

`define PC_WIDTH     32
`define LREG_WIDTH   5   // architectural regs
`define PREG_WIDTH   6   // physical regs

`endif

//--- rtl/rob_entry_array.sv
`include "rob_config.svh"

module rob_entry_array (
    input  logic                  clock,
    input  logic                  reset_n,
    input  rob_pkg::rob_enq_t     enq0,
    input  rob_pkg::rob_enq_t     enq1,
    input  rob_pkg::rob_id_t      enq_ptr,
    input  rob_pkg::rob_cmpl_t    intwb,
    input  rob_pkg::rob_cmpl_t    sq_cmpl,
    input  logic                  commit_fire,
    input  rob_pkg::rob_id_t      deq_ptr,
    input  logic [`ROB_SIZE-1:0]  rollback_mask,
    output logic [`ROB_SIZE-1:0]  entry_valid,
    output logic [`ROB_SIZE-1:0]  entry_complete,
    output logic [`ROB_SIZE-1:0]  entry_skip,
    output rob_pkg::rob_payload_t entry_payload [`ROB_SIZE]
);

    localparam int IDX_W = `ROB_SIZE_LOG;

    logic [IDX_W-1:0]     enq0_idx;
    logic [IDX_W-1:0]     enq1_idx;
    logic [IDX_W-1:0]     deq_idx;
    logic [`ROB_SIZE-1:0] enq0_hit;
    logic [`ROB_SIZE-1:0] enq1_hit;
    logic [`ROB_SIZE-1:0] enq_set;
    logic [`ROB_SIZE-1:0] cmpl_set;
    logic [`ROB_SIZE-1:0] skip_set;
    logic [`ROB_SIZE-1:0] clr;

    // completion source addressing entry idx
    function automatic logic cmpl_hit(rob_pkg::rob_cmpl_t c, int idx);
        return c.valid && (c.robid[IDX_W-1:0] == IDX_W'(idx));
    endfunction

    assign enq0_idx = enq_ptr[IDX_W-1:0];
    assign enq1_idx = enq0_idx + IDX_W'(1);   // enq1 lands right after enq0
    assign deq_idx  = deq_ptr[IDX_W-1:0];

    always_comb begin
        for (int i = 0; i < `ROB_SIZE; i++) begin
            enq0_hit[i] = enq0.valid && (enq0_idx == IDX_W'(i));
            enq1_hit[i] = enq1.valid && (enq1_idx == IDX_W'(i));
            cmpl_set[i] = cmpl_hit(intwb, i) || cmpl_hit(sq_cmpl, i);
            // mmio is tied low on the int side
            skip_set[i] = (cmpl_hit(intwb, i) && intwb.mmio) ||
                          (cmpl_hit(sq_cmpl, i) && sq_cmpl.mmio);
            clr[i]      = (commit_fire && (deq_idx == IDX_W'(i))) || rollback_mask[i];
        end
    end

    assign enq_set = enq0_hit | enq1_hit;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            entry_valid    <= '0;
            entry_complete <= '0;
            entry_skip     <= '0;
        end else begin
            for (int i = 0; i < `ROB_SIZE; i++) begin
                if (clr[i]) begin
                    entry_valid[i]    <= 1'b0;
                    entry_complete[i] <= 1'b0;
                    entry_skip[i]     <= 1'b0;
                end else if (enq_set[i]) begin   // fresh entry starts incomplete
                    entry_valid[i]    <= 1'b1;
                    entry_complete[i] <= 1'b0;
                    entry_skip[i]     <= 1'b0;
                end else begin
                    entry_complete[i] <= entry_complete[i] | cmpl_set[i];
                    entry_skip[i]     <= entry_skip[i] | skip_set[i];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `ROB_SIZE; i++) begin
            if (enq0_hit[i]) begin
                entry_payload[i] <= enq0.payload;
            end else if (enq1_hit[i]) begin
                entry_payload[i] <= enq1.payload;
            end
        end
    end

    // dispatch must never overrun the head, there is no full check
    a_enq_into_free: assert property (@(posedge clock) disable iff (!reset_n)
        !(|(enq_set & entry_valid)));

    a_cmpl_on_valid: assert property (@(posedge clock) disable iff (!reset_n)
        !(|(cmpl_set & ~entry_valid)));

endmodule

//--- rtl/rob_flush_ctrl.sv
`include "rob_config.svh"

module rob_flush_ctrl (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 enq0_valid,
    input  logic                 enq1_valid,
    input  logic                 commit_fire,
    input  logic                 flush_valid,
    input  rob_pkg::rob_id_t     flush_robid,
    input  logic [`ROB_SIZE-1:0] entry_valid,
    output rob_pkg::rob_id_t     enq_ptr,
    output rob_pkg::rob_id_t     deq_ptr,
    output rob_pkg::rob_id_t     walk_ptr,
    output rob_pkg::rob_state_t  state,
    output logic [`ROB_SIZE-1:0] rollback_mask
);

    localparam int IDX_W = `ROB_SIZE_LOG;

    rob_pkg::rob_state_t next_state;
    rob_pkg::rob_id_t    flush_id_q;
    rob_pkg::rob_id_t    enq_num;
    rob_pkg::rob_id_t    rb_limit;
    logic [IDX_W-1:0]    walk1_idx;

    assign enq_num   = rob_pkg::rob_id_t'(enq0_valid) + rob_pkg::rob_id_t'(enq1_valid);
    assign walk1_idx = walk_ptr[IDX_W-1:0] + IDX_W'(1);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            enq_ptr <= '0;
        end else if (state == rob_pkg::ROLLBACK) begin
            enq_ptr <= flush_id_q + rob_pkg::rob_id_t'(1);   // refill right after the branch
        end else begin
            enq_ptr <= enq_ptr + enq_num;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            deq_ptr <= '0;
        end else begin
            deq_ptr <= deq_ptr + rob_pkg::rob_id_t'(commit_fire);
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            walk_ptr <= '0;
        end else if (state == rob_pkg::ROLLBACK) begin
            walk_ptr <= deq_ptr;   // walk restarts at head
        end else if (state == rob_pkg::WALK) begin
            walk_ptr <= walk_ptr + rob_pkg::rob_id_t'(2);
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            flush_id_q <= '0;
        end else if (flush_valid) begin
            flush_id_q <= flush_robid;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            rob_pkg::IDLE: begin
                if (flush_valid) next_state = rob_pkg::ROLLBACK;
            end
            rob_pkg::ROLLBACK: begin
                next_state = flush_valid ? rob_pkg::ROLLBACK : rob_pkg::WALK;
            end
            rob_pkg::WALK: begin
                if (flush_valid) begin
                    next_state = rob_pkg::ROLLBACK;
                end else if (!entry_valid[walk1_idx]) begin   // last pair shown
                    next_state = rob_pkg::IDLE;
                end
            end
            default: next_state = rob_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= rob_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // younger entries sit at offsets 1 .. rb_limit-1 past the flush id
    // the wrap bit keeps a full buffer distinct from an empty range
    assign rb_limit = enq_ptr - flush_id_q;

    always_comb begin
        logic [IDX_W-1:0] offset;
        for (int i = 0; i < `ROB_SIZE; i++) begin
            offset           = IDX_W'(i) - flush_id_q[IDX_W-1:0];
            rollback_mask[i] = (state == rob_pkg::ROLLBACK) && (offset != '0) &&
                               ({1'b0, offset} < rb_limit);
        end
    end

    // rollback hands over to a walk that starts at the unmoved head
    a_rollback_to_walk: assert property (@(posedge clock) disable iff (!reset_n)
        (state == rob_pkg::ROLLBACK) |=> (state != rob_pkg::IDLE) && (walk_ptr == deq_ptr));

endmodule

//--- rtl/rob_pkg.sv
package rob_pkg;

`include "rob_config.svh"

    // index plus wrap flag
    typedef logic [`ROB_SIZE_LOG:0] rob_id_t;

    typedef struct packed {
        logic [`PC_WIDTH-1:0]   pc;
        logic [`LREG_WIDTH-1:0] lrd;
        logic [`PREG_WIDTH-1:0] prd;
        logic [`PREG_WIDTH-1:0] old_prd;   // freed at commit
        logic                   need_to_wb;
    } rob_payload_t;

    typedef struct packed {
        logic         valid;
        rob_payload_t payload;
    } rob_enq_t;

    // shared by int writeback and store queue
    typedef struct packed {
        logic    valid;
        rob_id_t robid;
        logic    mmio;
    } rob_cmpl_t;

    typedef struct packed {
        logic         valid;
        rob_id_t      robid;   // lets the store queue drain
        logic         skip;
        rob_payload_t payload;
    } rob_commit_t;

    // rename table rebuild after a flush
    typedef struct packed {
        logic                   valid;
        logic                   complete;
        logic [`LREG_WIDTH-1:0] lrd;
        logic [`PREG_WIDTH-1:0] prd;
    } rob_walk_t;

    typedef enum logic [1:0] {
        IDLE     = 2'b00,
        ROLLBACK = 2'b01,
        WALK     = 2'b10
    } rob_state_t;

endpackage

//--- rtl/rob_retire_select.sv
`include "rob_config.svh"

module rob_retire_select (
    input  rob_pkg::rob_id_t      deq_ptr,
    input  rob_pkg::rob_id_t      walk_ptr,
    input  rob_pkg::rob_state_t   state,
    input  logic                  flush_valid,
    input  logic [`ROB_SIZE-1:0]  entry_valid,
    input  logic [`ROB_SIZE-1:0]  entry_complete,
    input  logic [`ROB_SIZE-1:0]  entry_skip,
    input  rob_pkg::rob_payload_t entry_payload [`ROB_SIZE],
    output rob_pkg::rob_commit_t  commit0,
    output logic                  commit_fire,
    output rob_pkg::rob_walk_t    walk0,
    output rob_pkg::rob_walk_t    walk1
);

    localparam int IDX_W = `ROB_SIZE_LOG;

    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] w0_idx;
    logic [IDX_W-1:0] w1_idx;
    logic             is_walk;

    assign head_idx = deq_ptr[IDX_W-1:0];
    assign w0_idx   = walk_ptr[IDX_W-1:0];
    assign w1_idx   = w0_idx + IDX_W'(1);
    assign is_walk  = (state == rob_pkg::WALK);

    // head retires only in a quiet idle cycle
    assign commit_fire = (state == rob_pkg::IDLE) && !flush_valid &&
                         entry_valid[head_idx] && entry_complete[head_idx];

    always_comb begin
        commit0.valid   = commit_fire;
        commit0.robid   = deq_ptr;
        commit0.skip    = entry_skip[head_idx];   // set by an mmio store completion
        commit0.payload = entry_payload[head_idx];
    end

    // only entries that write a register matter to the rename table
    always_comb begin
        walk0.valid    = is_walk && entry_valid[w0_idx] && entry_payload[w0_idx].need_to_wb;
        walk0.complete = entry_complete[w0_idx];
        walk0.lrd      = entry_payload[w0_idx].lrd;
        walk0.prd      = entry_payload[w0_idx].prd;

        walk1.valid    = is_walk && entry_valid[w1_idx] && entry_payload[w1_idx].need_to_wb;
        walk1.complete = entry_complete[w1_idx];
        walk1.lrd      = entry_payload[w1_idx].lrd;
        walk1.prd      = entry_payload[w1_idx].prd;
    end

endmodule

//--- rtl/rob_top.sv
`include "rob_config.svh"

module rob_top (
    input  logic                 clock,
    input  logic                 reset_n,
    input  rob_pkg::rob_enq_t    enq0,
    input  rob_pkg::rob_enq_t    enq1,
    input  rob_pkg::rob_cmpl_t   intwb,
    input  rob_pkg::rob_cmpl_t   sq_cmpl,
    input  logic                 flush_valid,
    input  rob_pkg::rob_id_t     flush_robid,
    output rob_pkg::rob_commit_t commit0,
    output rob_pkg::rob_walk_t   walk0,
    output rob_pkg::rob_walk_t   walk1,
    output rob_pkg::rob_state_t  rob_state,
    output rob_pkg::rob_id_t     enq_robid
);

    rob_pkg::rob_id_t      enq_ptr;
    rob_pkg::rob_id_t      deq_ptr;
    rob_pkg::rob_id_t      walk_ptr;
    logic [`ROB_SIZE-1:0]  rollback_mask;
    logic                  commit_fire;
    logic [`ROB_SIZE-1:0]  entry_valid;
    logic [`ROB_SIZE-1:0]  entry_complete;
    logic [`ROB_SIZE-1:0]  entry_skip;
    rob_pkg::rob_payload_t entry_payload [`ROB_SIZE];

    assign enq_robid = enq_ptr;   // id handed to the next enq0

    rob_entry_array i_entry_array (
        .clock          (clock),
        .reset_n        (reset_n),
        .enq0           (enq0),
        .enq1           (enq1),
        .enq_ptr        (enq_ptr),
        .intwb          (intwb),
        .sq_cmpl        (sq_cmpl),
        .commit_fire    (commit_fire),
        .deq_ptr        (deq_ptr),
        .rollback_mask  (rollback_mask),
        .entry_valid    (entry_valid),
        .entry_complete (entry_complete),
        .entry_skip     (entry_skip),
        .entry_payload  (entry_payload)
    );

    rob_flush_ctrl i_flush_ctrl (
        .clock         (clock),
        .reset_n       (reset_n),
        .enq0_valid    (enq0.valid),
        .enq1_valid    (enq1.valid),
        .commit_fire   (commit_fire),
        .flush_valid   (flush_valid),
        .flush_robid   (flush_robid),
        .entry_valid   (entry_valid),
        .enq_ptr       (enq_ptr),
        .deq_ptr       (deq_ptr),
        .walk_ptr      (walk_ptr),
        .state         (rob_state),
        .rollback_mask (rollback_mask)
    );

    rob_retire_select i_retire_select (
        .deq_ptr        (deq_ptr),
        .walk_ptr       (walk_ptr),
        .state          (rob_state),
        .flush_valid    (flush_valid),
        .entry_valid    (entry_valid),
        .entry_complete (entry_complete),
        .entry_skip     (entry_skip),
        .entry_payload  (entry_payload),
        .commit0        (commit0),
        .commit_fire    (commit_fire),
        .walk0          (walk0),
        .walk1          (walk1)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert --timescale 1ns/100ps --top-module rob_tb -f all.f -o rob_sim \
    > build.log 2>&1 \
    && ./obj_dir/rob_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

//--- verif/rob_tb.sv
`include "rob_config.svh"

module rob_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IDX_W = `ROB_SIZE_LOG;

    typedef struct packed {
        logic [1:0]       n_enq;
        logic             wb_v;
        rob_pkg::rob_id_t wb_id;
        logic             sq_v;
        rob_pkg::rob_id_t sq_id;
        logic             sq_mmio;
        logic             fl_v;
        rob_pkg::rob_id_t fl_id;
    } stim_row_t;

    logic                 clock;
    logic                 reset_n;
    rob_pkg::rob_enq_t    enq0;
    rob_pkg::rob_enq_t    enq1;
    rob_pkg::rob_cmpl_t   intwb;
    rob_pkg::rob_cmpl_t   sq_cmpl;
    logic                 flush_valid;
    rob_pkg::rob_id_t     flush_robid;
    rob_pkg::rob_commit_t commit0;
    rob_pkg::rob_walk_t   walk0;
    rob_pkg::rob_walk_t   walk1;
    rob_pkg::rob_state_t  rob_state;
    rob_pkg::rob_id_t     enq_robid;

    stim_row_t rows[$];
    int        errors;
    int        checks;
    int        cycles;
    int        cycle_limit;
    logic [31:0] lfsr;

    // reference queue
    logic [`ROB_SIZE-1:0]  m_valid;
    logic [`ROB_SIZE-1:0]  m_complete;
    logic [`ROB_SIZE-1:0]  m_skip;
    rob_pkg::rob_payload_t m_payload [`ROB_SIZE];
    rob_pkg::rob_id_t      m_enq;
    rob_pkg::rob_id_t      m_deq;
    rob_pkg::rob_id_t      m_walk;
    rob_pkg::rob_id_t      m_flush_id;
    rob_pkg::rob_state_t   m_state;

    tb_clock_gen i_clock_gen (.clock(clock), .reset_n(reset_n));

    rob_top i_dut (
        .clock       (clock),
        .reset_n     (reset_n),
        .enq0        (enq0),
        .enq1        (enq1),
        .intwb       (intwb),
        .sq_cmpl     (sq_cmpl),
        .flush_valid (flush_valid),
        .flush_robid (flush_robid),
        .commit0     (commit0),
        .walk0       (walk0),
        .walk1       (walk1),
        .rob_state   (rob_state),
        .enq_robid   (enq_robid)
    );

    function automatic logic take_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h8020_0003;   // galois taps 32,22,2,1
        return b;
    endfunction

    function automatic rob_pkg::rob_payload_t random_payload();
        logic [$bits(rob_pkg::rob_payload_t)-1:0] bits;
        for (int i = 0; i < $bits(bits); i++) begin
            bits[i] = take_bit();
        end
        return rob_pkg::rob_payload_t'(bits);
    endfunction

    // ids below zero mean no strobe
    function automatic void add_row(int count, int n_enq, int wb_id, int sq_id, int mmio,
                                    int fl_id);
        stim_row_t r;
        r.n_enq   = 2'(n_enq);
        r.wb_v    = (wb_id >= 0);
        r.wb_id   = rob_pkg::rob_id_t'(wb_id);
        r.sq_v    = (sq_id >= 0);
        r.sq_id   = rob_pkg::rob_id_t'(sq_id);
        r.sq_mmio = (mmio != 0);
        r.fl_v    = (fl_id >= 0);
        r.fl_id   = rob_pkg::rob_id_t'(fl_id);
        for (int i = 0; i < count; i++) begin
            rows.push_back(r);
        end
    endfunction

    task automatic check(string name, logic [63:0] actual, logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    function automatic logic commit_expected();
        logic [IDX_W-1:0] head;
        head = m_deq[IDX_W-1:0];
        return (m_state == rob_pkg::IDLE) && !flush_valid && m_valid[head] && m_complete[head];
    endfunction

    task automatic verify_walk(string name, rob_pkg::rob_walk_t w, logic [IDX_W-1:0] slot);
        logic exp_v;
        exp_v = (m_state == rob_pkg::WALK) && m_valid[slot] && m_payload[slot].need_to_wb;
        check({name, ".valid"}, 64'(w.valid), 64'(exp_v));
        if (exp_v) begin
            check({name, ".complete"}, 64'(w.complete), 64'(m_complete[slot]));
            check({name, ".lrd"}, 64'(w.lrd), 64'(m_payload[slot].lrd));
            check({name, ".prd"}, 64'(w.prd), 64'(m_payload[slot].prd));
        end
    endtask

    task automatic verify_outputs();
        logic [IDX_W-1:0] head;
        logic             fire;
        head = m_deq[IDX_W-1:0];
        fire = commit_expected();
        check("rob_state", 64'(rob_state), 64'(m_state));
        check("enq_robid", 64'(enq_robid), 64'(m_enq));
        check("commit0.valid", 64'(commit0.valid), 64'(fire));
        if (fire) begin
            check("commit0.robid", 64'(commit0.robid), 64'(m_deq));
            check("commit0.skip", 64'(commit0.skip), 64'(m_skip[head]));
            check("commit0.payload", 64'(commit0.payload), 64'(m_payload[head]));
        end
        verify_walk("walk0", walk0, m_walk[IDX_W-1:0]);
        verify_walk("walk1", walk1, m_walk[IDX_W-1:0] + IDX_W'(1));
    endtask

    task automatic step_model(stim_row_t r);
        logic [IDX_W-1:0]    slot;
        logic                fire;
        rob_pkg::rob_id_t    id;
        rob_pkg::rob_state_t nxt;
        fire = commit_expected();
        slot = m_walk[IDX_W-1:0] + IDX_W'(1);
        nxt  = m_state;
        case (m_state)
            rob_pkg::IDLE:     nxt = r.fl_v ? rob_pkg::ROLLBACK : rob_pkg::IDLE;
            rob_pkg::ROLLBACK: nxt = r.fl_v ? rob_pkg::ROLLBACK : rob_pkg::WALK;
            default: begin
                if (r.fl_v) begin
                    nxt = rob_pkg::ROLLBACK;
                end else if (!m_valid[slot]) begin   // walk ends after the last pair
                    nxt = rob_pkg::IDLE;
                end
            end
        endcase
        if (r.wb_v) m_complete[r.wb_id[IDX_W-1:0]] = 1'b1;
        if (r.sq_v) begin
            m_complete[r.sq_id[IDX_W-1:0]] = 1'b1;
            if (r.sq_mmio) m_skip[r.sq_id[IDX_W-1:0]] = 1'b1;
        end
        if (fire) begin
            m_valid[m_deq[IDX_W-1:0]] = 1'b0;
            m_deq = m_deq + rob_pkg::rob_id_t'(1);
        end
        for (int k = 0; k < 2; k++) begin
            if ((k == 0 && enq0.valid) || (k == 1 && enq1.valid)) begin
                slot             = m_enq[IDX_W-1:0] + IDX_W'(k);
                m_valid[slot]    = 1'b1;
                m_complete[slot] = 1'b0;
                m_skip[slot]     = 1'b0;
                m_payload[slot]  = (k == 0) ? enq0.payload : enq1.payload;
            end
        end
        if (m_state == rob_pkg::ROLLBACK) begin
            // drop everything younger than the flushing instruction
            id = m_flush_id + rob_pkg::rob_id_t'(1);
            while (id != m_enq) begin
                m_valid[id[IDX_W-1:0]] = 1'b0;
                id = id + rob_pkg::rob_id_t'(1);
            end
            m_enq  = m_flush_id + rob_pkg::rob_id_t'(1);
            m_walk = m_deq;
        end else begin
            m_enq = m_enq + rob_pkg::rob_id_t'(r.n_enq);
            if (m_state == rob_pkg::WALK) m_walk = m_walk + rob_pkg::rob_id_t'(2);
        end
        if (r.fl_v) m_flush_id = r.fl_id;
        m_state = nxt;
    endtask

    always @(posedge clock) begin
        if (reset_n) begin
            cycles++;
            if (cycles > cycle_limit) begin
                $display("timeout: run did not finish within %0d cycles", cycle_limit);
                $display("Done: errors found");
                $finish;
            end
        end
    end

    initial begin
        int n_flush;
        lfsr        = 32'h4538;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        cycle_limit = 1000;
        n_flush     = 0;
        enq0        = '0;
        enq1        = '0;
        intwb       = '0;
        sq_cmpl     = '0;
        flush_valid = 1'b0;
        flush_robid = '0;
        m_valid     = '0;
        m_complete  = '0;
        m_skip      = '0;
        m_enq       = '0;
        m_deq       = '0;
        m_walk      = '0;
        m_flush_id  = '0;
        m_state     = rob_pkg::IDLE;

        // count, enq, intwb id, sq id, mmio, flush id
        add_row(1, 0, -1, -1, 0, -1);    // reset values
        add_row(2, 2, -1, -1, 0, -1);    // ids 0..3
        add_row(1, 0,  1, -1, 0, -1);
        add_row(1, 0, -1,  0, 1, -1);    // mmio store at the head
        add_row(1, 0,  3, -1, 0, -1);
        add_row(1, 0, -1,  2, 0, -1);
        add_row(2, 0, -1, -1, 0, -1);
        add_row(3, 2, -1, -1, 0, -1);    // ids 4..9
        add_row(1, 0,  4, -1, 0, -1);
        add_row(1, 0,  6, -1, 0, -1);
        add_row(1, 0, -1, -1, 0,  7);    // drops 8 and 9
        add_row(6, 0, -1, -1, 0, -1);
        add_row(1, 0,  5, -1, 0, -1);
        add_row(1, 0,  7, -1, 0, -1);
        add_row(3, 0, -1, -1, 0, -1);
        add_row(5, 2, -1, -1, 0, -1);    // ids 8..17 wrap the index
        add_row(1, 0,  8, -1, 0, -1);
        add_row(1, 0, -1,  9, 1, -1);
        add_row(1, 0, -1, -1, 0, 10);    // rollback across the wrap
        add_row(6, 0, -1, -1, 0, -1);
        add_row(1, 0, 10, -1, 0, -1);
        add_row(1, 0, -1, -1, 0, -1);
        add_row(1, 2, -1, -1, 0, -1);
        add_row(1, 0, 12, -1, 0, -1);
        add_row(1, 0, 11, -1, 0, -1);
        add_row(4, 0, -1, -1, 0, -1);

        foreach (rows[i]) begin
            if (rows[i].fl_v) n_flush++;
        end
        cycle_limit = rows.size() + 40 * n_flush;

        wait (reset_n == 1'b1);
        foreach (rows[i]) begin
            @(negedge clock);
            enq0.valid    = (rows[i].n_enq != 2'd0);
            enq0.payload  = random_payload();
            enq1.valid    = (rows[i].n_enq == 2'd2);
            enq1.payload  = random_payload();
            intwb.valid   = rows[i].wb_v;
            intwb.robid   = rows[i].wb_id;
            intwb.mmio    = 1'b0;   // tied off on the int side
            sq_cmpl.valid = rows[i].sq_v;
            sq_cmpl.robid = rows[i].sq_id;
            sq_cmpl.mmio  = rows[i].sq_mmio;
            flush_valid   = rows[i].fl_v;
            flush_robid   = rows[i].fl_id;
            #2;
            verify_outputs();
            step_model(rows[i]);
        end
        while (rob_state != rob_pkg::IDLE) begin
            @(negedge clock);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
module tb_clock_gen (
    output logic clock,
    output logic reset_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 5;

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;   // 8 ns period
    end

    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;   // released away from the rising edge
    end

endmodule
